// ==== hw/icache_config.svh ====
// icache configuration
// address split, way count and word width for the two-way instruction cache
// tag 31..10, index 9..4, offset 3..0

`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// fetch and memory address width
`define ICACHE_ADDR_W 32

// address split
`define ICACHE_TAG_W 22
`define ICACHE_INDEX_W 6   // 64 sets
`define ICACHE_OFFSET_W 4  // 16-byte lines

// associativity
`define ICACHE_WAYS 2

// one fetch word, also one bus beat
`define ICACHE_WORD_W 64

`endif

// ==== hw/icache_csr.sv ====
// icache register block
// enable bit, pending flush flag and saturating hit / miss counters
// reads are combinational from the register select

`default_nettype none

module icache_csr (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  csr_we_i,
  input  icache_pkg::csr_addr_t csr_addr_i,
  input  icache_pkg::csr_data_t csr_wdata_i,
  output icache_pkg::csr_data_t csr_rdata_o,
  input  logic                  hit_i,
  input  logic                  miss_i,
  input  logic                  flush_done_i,
  output logic                  cache_en_o,
  output logic                  flush_req_o
);

  logic                  en_q;
  logic                  flush_pend_q;
  icache_pkg::csr_data_t hit_cnt_q;
  icache_pkg::csr_data_t miss_cnt_q;

  // counters stick at all ones
  function automatic icache_pkg::csr_data_t sat_inc(icache_pkg::csr_data_t cnt);
    return (&cnt) ? cnt : cnt + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      en_q         <= 1'b1;  // cache comes up enabled
      flush_pend_q <= 1'b0;
      hit_cnt_q    <= '0;
      miss_cnt_q   <= '0;
    end else begin
      if (flush_done_i) flush_pend_q <= 1'b0;

      if (csr_we_i && csr_addr_i == icache_pkg::CSR_CTRL) begin
        en_q <= csr_wdata_i[0];
        if (csr_wdata_i[1]) flush_pend_q <= 1'b1;  // new command wins over done
      end

      if (csr_we_i && csr_addr_i == icache_pkg::CSR_HITS) hit_cnt_q <= '0;
      else if (hit_i) hit_cnt_q <= sat_inc(hit_cnt_q);

      if (csr_we_i && csr_addr_i == icache_pkg::CSR_MISSES) miss_cnt_q <= '0;
      else if (miss_i) miss_cnt_q <= sat_inc(miss_cnt_q);
    end
  end

  always_comb begin
    case (csr_addr_i)
      icache_pkg::CSR_CTRL:   csr_rdata_o = {30'd0, flush_pend_q, en_q};
      icache_pkg::CSR_HITS:   csr_rdata_o = hit_cnt_q;
      icache_pkg::CSR_MISSES: csr_rdata_o = miss_cnt_q;
      default:                csr_rdata_o = '0;
    endcase
  end

  assign cache_en_o  = en_q;
  assign flush_req_o = flush_pend_q;

endmodule

`default_nettype wire

// ==== hw/icache_ctrl.sv ====
// icache controller
// fetch FSM with tag compare, valid bits, victim choice and line refill
// disabled cache turns each fetch into an uncached single beat read
// valid bits live in flops so a flush clears them in one cycle

`include "icache_config.svh"
`default_nettype none

module icache_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  // fetch side
  input  logic                    fetch_valid_i,
  input  icache_pkg::addr_t       fetch_addr_i,
  output logic                    fetch_ready_o,
  output logic                    resp_valid_o,
  output icache_pkg::word_t       resp_data_o,
  input  logic                    resp_ready_i,
  // memory side
  output logic                    mem_ar_valid_o,
  input  logic                    mem_ar_ready_i,
  output icache_pkg::addr_t       mem_ar_addr_o,
  output logic                    mem_ar_len_o,
  input  logic                    mem_r_valid_i,
  input  icache_pkg::word_t       mem_r_data_i,
  output logic                    mem_r_ready_o,
  // register block
  input  logic                    cache_en_i,
  input  logic                    flush_req_i,
  output logic                    flush_done_o,
  output logic                    hit_o,
  output logic                    miss_o,
  // tag and line rams
  output icache_pkg::index_t      ram_addr_o,
  output logic [`ICACHE_WAYS-1:0] tag_we_o,
  output logic [`ICACHE_WAYS-1:0] data_we_o,
  output icache_pkg::tag_t        tag_wdata_o,
  output icache_pkg::line_t       line_wdata_o,
  input  icache_pkg::tag_t        tag_rdata_i [`ICACHE_WAYS],
  input  icache_pkg::line_t       line_rdata_i [`ICACHE_WAYS]
);

  localparam int SETS = 1 << `ICACHE_INDEX_W;
  localparam int TAG_LSB = `ICACHE_INDEX_W + `ICACHE_OFFSET_W;
  localparam int HALF_BIT = `ICACHE_OFFSET_W - 1;  // upper or lower word of the line
  localparam int WORD_W = `ICACHE_WORD_W;

  icache_pkg::ctrl_state_t state_q;
  icache_pkg::ctrl_state_t state_d;
  logic                    rdy_q;
  logic [SETS-1:0]         valid_q [`ICACHE_WAYS];
  icache_pkg::way_t        tgl_q;   // free-running victim toggle
  logic                    beat_q;  // first refill beat seen

  icache_pkg::addr_t       addr_q;
  icache_pkg::way_t        way_q;   // way being refilled
  icache_pkg::word_t       beat0_q;
  icache_pkg::word_t       resp_q;

  icache_pkg::tag_t        addr_tag;
  icache_pkg::index_t      addr_idx;
  logic [`ICACHE_WAYS-1:0] way_hit;
  icache_pkg::way_t        hit_way;
  icache_pkg::way_t        victim;
  logic                    hit;
  logic                    accept;
  logic                    last_beat;
  logic [`ICACHE_WAYS-1:0] fill_we;

  assign addr_tag = addr_q[`ICACHE_ADDR_W-1:TAG_LSB];
  assign addr_idx = addr_q[TAG_LSB-1:`ICACHE_OFFSET_W];

  assign fetch_ready_o = rdy_q && !flush_req_i;
  assign accept        = fetch_valid_i && fetch_ready_o;
  assign last_beat     = (state_q == icache_pkg::MISS_R) && mem_r_valid_i && beat_q;

  // tag compare and victim choice, valid during LOOKUP
  always_comb begin
    hit_way = '0;
    victim  = tgl_q;  // both ways valid
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      way_hit[w] = valid_q[w][addr_idx] && (tag_rdata_i[w] == addr_tag);
      if (way_hit[w]) hit_way = icache_pkg::way_t'(w);
    end
    // lowest invalid way wins
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[w][addr_idx]) victim = icache_pkg::way_t'(w);
    end
  end

  assign hit = cache_en_i && (|way_hit);

  always_comb begin
    state_d = state_q;
    case (state_q)
      icache_pkg::IDLE: begin
        if (flush_req_i) state_d = icache_pkg::FLUSH;
        else if (accept) state_d = icache_pkg::LOOKUP;
      end
      icache_pkg::LOOKUP: begin
        if (!cache_en_i) state_d = icache_pkg::BYP_AR;
        else if (hit) state_d = icache_pkg::RESP;
        else state_d = icache_pkg::MISS_AR;
      end
      icache_pkg::MISS_AR: if (mem_ar_ready_i) state_d = icache_pkg::MISS_R;
      icache_pkg::MISS_R:  if (last_beat) state_d = icache_pkg::RESP;
      icache_pkg::BYP_AR:  if (mem_ar_ready_i) state_d = icache_pkg::BYP_R;
      icache_pkg::BYP_R:   if (mem_r_valid_i) state_d = icache_pkg::RESP;
      icache_pkg::RESP:    if (resp_ready_i) state_d = icache_pkg::IDLE;
      icache_pkg::FLUSH:   state_d = icache_pkg::IDLE;  // all valids cleared this cycle
      default:             state_d = icache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= icache_pkg::IDLE;
      rdy_q   <= 1'b0;
      tgl_q   <= '0;
      beat_q  <= 1'b0;
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        valid_q[w] <= '0;
      end
    end else begin
      state_q <= state_d;
      rdy_q   <= (state_d == icache_pkg::IDLE);
      tgl_q   <= tgl_q + 1'b1;

      if (state_q == icache_pkg::LOOKUP) beat_q <= 1'b0;
      else if (state_q == icache_pkg::MISS_R && mem_r_valid_i) beat_q <= 1'b1;

      if (state_q == icache_pkg::FLUSH) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
          valid_q[w] <= '0;
        end
      end else if (last_beat) begin
        valid_q[way_q][addr_idx] <= 1'b1;  // line complete
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (accept) addr_q <= fetch_addr_i;
    if (state_q == icache_pkg::LOOKUP) way_q <= victim;
    if (state_q == icache_pkg::MISS_R && mem_r_valid_i && !beat_q) begin
      beat0_q <= mem_r_data_i;  // low word of the line
    end

    if (state_q == icache_pkg::LOOKUP && hit) begin
      resp_q <= addr_q[HALF_BIT] ? line_rdata_i[hit_way][2*WORD_W-1:WORD_W]
                                 : line_rdata_i[hit_way][WORD_W-1:0];
    end else if (last_beat) begin
      resp_q <= addr_q[HALF_BIT] ? mem_r_data_i : beat0_q;
    end else if (state_q == icache_pkg::BYP_R && mem_r_valid_i) begin
      resp_q <= mem_r_data_i;
    end
  end

  // refill writes tag and line of the chosen way together
  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      fill_we[w] = last_beat && (way_q == icache_pkg::way_t'(w));
    end
  end

  assign tag_we_o     = fill_we;
  assign data_we_o    = fill_we;
  assign tag_wdata_o  = addr_tag;
  assign line_wdata_o = {mem_r_data_i, beat0_q};
  // read at the incoming index while idle so LOOKUP sees the set
  assign ram_addr_o = (state_q == icache_pkg::IDLE) ?
                      fetch_addr_i[TAG_LSB-1:`ICACHE_OFFSET_W] : addr_idx;

  assign mem_ar_valid_o = (state_q == icache_pkg::MISS_AR) || (state_q == icache_pkg::BYP_AR);
  assign mem_ar_len_o   = (state_q == icache_pkg::MISS_AR);  // two beats for a line
  assign mem_ar_addr_o  = (state_q == icache_pkg::MISS_AR) ?
                          {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}} :
                          {addr_q[`ICACHE_ADDR_W-1:HALF_BIT], {HALF_BIT{1'b0}}};
  assign mem_r_ready_o  = (state_q == icache_pkg::MISS_R) || (state_q == icache_pkg::BYP_R);

  assign resp_valid_o = (state_q == icache_pkg::RESP);
  assign resp_data_o  = resp_q;

  // a bypassed fetch counts as a miss
  assign hit_o        = (state_q == icache_pkg::LOOKUP) && hit;
  assign miss_o       = (state_q == icache_pkg::LOOKUP) && !hit;
  assign flush_done_o = (state_q == icache_pkg::FLUSH);

endmodule

`default_nettype wire

// ==== hw/icache_pkg.sv ====
// icache package
// shared types for the instruction cache, sized from the config macros
// also holds the register map and the controller state encoding

`include "icache_config.svh"
`default_nettype none

package icache_pkg;

  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
  typedef logic [`ICACHE_TAG_W-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;
  typedef logic [`ICACHE_WORD_W-1:0] word_t;

  // low word is offset 0..7, high word offset 8..15
  typedef logic [2*`ICACHE_WORD_W-1:0] line_t;

  // register bus
  typedef logic [1:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  localparam csr_addr_t CSR_CTRL = 2'd0;    // bit 0 enable, bit 1 flush
  localparam csr_addr_t CSR_HITS = 2'd1;
  localparam csr_addr_t CSR_MISSES = 2'd2;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MISS_AR,   // line burst request
    MISS_R,    // two refill beats
    BYP_AR,    // uncached single beat request
    BYP_R,
    RESP,
    FLUSH
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/icache_ram.sv ====
// icache ram
// synchronous single-port memory with one cycle read latency
// the entry type is a parameter so one module holds tags or whole lines

`default_nettype none

module icache_ram #(
  parameter type data_t = icache_pkg::line_t,
  parameter int DEPTH = 64
) (
  input  logic               clk,
  input  icache_pkg::index_t addr_i,
  input  logic               we_i,
  input  data_t              wdata_i,
  output data_t              rdata_o
);

  data_t mem [DEPTH];

  // write first-free: a read on the write cycle returns the old entry
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
    rdata_o <= mem[addr_i];
  end

endmodule

`default_nettype wire

// ==== hw/icache_top.sv ====
// icache top level
// two-way read-only instruction cache: controller, register block
// and one tag ram plus one line ram per way

`include "icache_config.svh"
`default_nettype none

module icache_top (
  input  logic                  clk,
  input  logic                  rst,
  // fetch side
  input  logic                  fetch_valid_i,
  input  icache_pkg::addr_t     fetch_addr_i,
  output logic                  fetch_ready_o,
  output logic                  resp_valid_o,
  output icache_pkg::word_t     resp_data_o,
  input  logic                  resp_ready_i,
  // memory side
  output logic                  mem_ar_valid_o,
  input  logic                  mem_ar_ready_i,
  output icache_pkg::addr_t     mem_ar_addr_o,
  output logic                  mem_ar_len_o,
  input  logic                  mem_r_valid_i,
  input  icache_pkg::word_t     mem_r_data_i,
  output logic                  mem_r_ready_o,
  // register bus
  input  logic                  csr_we_i,
  input  icache_pkg::csr_addr_t csr_addr_i,
  input  icache_pkg::csr_data_t csr_wdata_i,
  output icache_pkg::csr_data_t csr_rdata_o
);

  localparam int SETS = 1 << `ICACHE_INDEX_W;

  logic                    cache_en;
  logic                    flush_req;
  logic                    flush_done;
  logic                    hit_pulse;
  logic                    miss_pulse;

  icache_pkg::index_t      ram_addr;
  logic [`ICACHE_WAYS-1:0] tag_we;
  logic [`ICACHE_WAYS-1:0] data_we;
  icache_pkg::tag_t        tag_wdata;
  icache_pkg::line_t       line_wdata;
  icache_pkg::tag_t        tag_rdata [`ICACHE_WAYS];
  icache_pkg::line_t       line_rdata [`ICACHE_WAYS];

  icache_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_o (fetch_ready_o),
    .resp_valid_o  (resp_valid_o),
    .resp_data_o   (resp_data_o),
    .resp_ready_i  (resp_ready_i),
    .mem_ar_valid_o(mem_ar_valid_o),
    .mem_ar_ready_i(mem_ar_ready_i),
    .mem_ar_addr_o (mem_ar_addr_o),
    .mem_ar_len_o  (mem_ar_len_o),
    .mem_r_valid_i (mem_r_valid_i),
    .mem_r_data_i  (mem_r_data_i),
    .mem_r_ready_o (mem_r_ready_o),
    .cache_en_i    (cache_en),
    .flush_req_i   (flush_req),
    .flush_done_o  (flush_done),
    .hit_o         (hit_pulse),
    .miss_o        (miss_pulse),
    .ram_addr_o    (ram_addr),
    .tag_we_o      (tag_we),
    .data_we_o     (data_we),
    .tag_wdata_o   (tag_wdata),
    .line_wdata_o  (line_wdata),
    .tag_rdata_i   (tag_rdata),
    .line_rdata_i  (line_rdata)
  );

  icache_csr u_csr (
    .clk         (clk),
    .rst         (rst),
    .csr_we_i    (csr_we_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .hit_i       (hit_pulse),
    .miss_i      (miss_pulse),
    .flush_done_i(flush_done),
    .cache_en_o  (cache_en),
    .flush_req_o (flush_req)
  );

  // one tag ram and one line ram per way, shared address
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    icache_ram #(
      .data_t(icache_pkg::tag_t),
      .DEPTH (SETS)
    ) u_tag_ram (
      .clk    (clk),
      .addr_i (ram_addr),
      .we_i   (tag_we[w]),
      .wdata_i(tag_wdata),
      .rdata_o(tag_rdata[w])
    );

    icache_ram #(
      .data_t(icache_pkg::line_t),
      .DEPTH (SETS)
    ) u_data_ram (
      .clk    (clk),
      .addr_i (ram_addr),
      .we_i   (data_we[w]),
      .wdata_i(line_wdata),
      .rdata_o(line_rdata[w])
    );
  end

endmodule

`default_nettype wire

// ==== icache_top.f ====
+incdir+hw
hw/icache_pkg.sv
hw/icache_ram.sv
hw/icache_csr.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tb/icache_asserts.sv
tb/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the icache testbench with Verilator and run it
# exit status is 0 only when the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f icache_top.f \
  --top-module icache_tb \
  -Mdir obj_dir \
  && ./obj_dir/Vicache_tb | tee /dev/stderr | grep -q "Regression passed" \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }

// ==== tb/icache_asserts.sv ====
// icache protocol assertions
// bound into the controller, checks fetch, response and memory request rules

`include "icache_config.svh"
`default_nettype none

module icache_asserts (
  input logic                    clk,
  input logic                    rst,
  input icache_pkg::ctrl_state_t state_i,
  input logic                    fetch_ready_i,
  input logic                    resp_valid_i,
  input logic                    resp_ready_i,
  input icache_pkg::word_t       resp_data_i,
  input logic                    mem_ar_valid_i,
  input logic                    mem_ar_ready_i,
  input icache_pkg::addr_t       mem_ar_addr_i,
  input logic                    mem_ar_len_i
);

  // no new fetch while a response is out
  a_ready_vs_resp: assert property (@(posedge clk) disable iff (rst)
    !(fetch_ready_i && resp_valid_i))
    else $error("fetch ready and response valid high together");

  a_ar_stable: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_i && !mem_ar_ready_i |=>
      mem_ar_valid_i && $stable(mem_ar_addr_i) && $stable(mem_ar_len_i))
    else $error("memory request changed while stalled");

  a_burst_aligned: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_i && mem_ar_len_i |-> mem_ar_addr_i[`ICACHE_OFFSET_W-1:0] == '0)
    else $error("burst address not line aligned");

  // ready flop must track the idle state
  a_ready_idle: assert property (@(posedge clk) disable iff (rst)
    fetch_ready_i |-> state_i == icache_pkg::IDLE)
    else $error("fetch ready high outside the idle state");

  a_resp_hold: assert property (@(posedge clk) disable iff (rst)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_data_i))
    else $error("response dropped or changed before ready");

endmodule

bind icache_ctrl icache_asserts i_asserts (
  .clk           (clk),
  .rst           (rst),
  .state_i       (state_q),
  .fetch_ready_i (fetch_ready_o),
  .resp_valid_i  (resp_valid_o),
  .resp_ready_i  (resp_ready_i),
  .resp_data_i   (resp_data_o),
  .mem_ar_valid_i(mem_ar_valid_o),
  .mem_ar_ready_i(mem_ar_ready_i),
  .mem_ar_addr_i (mem_ar_addr_o),
  .mem_ar_len_i  (mem_ar_len_o)
);

`default_nettype wire

// ==== tb/icache_tb.sv ====
// icache testbench
// table of fetches and register accesses against a memory model with random stalls
// memory word at 8-byte address A reads back as {A, ~A}

`default_nettype none

module icache_tb;

  typedef enum logic [1:0] {OP_FETCH, OP_CSR_WR, OP_CSR_RD} op_kind_t;
  typedef enum logic [1:0] {EXP_HIT, EXP_MISS, EXP_BYP, EXP_NONE} outcome_t;

  typedef struct packed {
    op_kind_t              kind;
    outcome_t              outcome;
    icache_pkg::addr_t     addr;   // fetch address, or register select in bits 1..0
    icache_pkg::csr_data_t data;
  } op_t;

  logic                  clk;
  logic                  rst;
  logic                  fetch_valid_i;
  icache_pkg::addr_t     fetch_addr_i;
  logic                  fetch_ready_o;
  logic                  resp_valid_o;
  icache_pkg::word_t     resp_data_o;
  logic                  resp_ready_i;
  logic                  mem_ar_valid_o;
  logic                  mem_ar_ready_i;
  icache_pkg::addr_t     mem_ar_addr_o;
  logic                  mem_ar_len_o;
  logic                  mem_r_valid_i;
  icache_pkg::word_t     mem_r_data_i;
  logic                  mem_r_ready_o;
  logic                  csr_we_i;
  icache_pkg::csr_addr_t csr_addr_i;
  icache_pkg::csr_data_t csr_wdata_i;
  icache_pkg::csr_data_t csr_rdata_o;

  op_t                   ops [$];
  bit                    table_loaded = 1'b0;
  icache_pkg::addr_t     ar_addr_log [$];  // accepted memory requests
  logic                  ar_len_log [$];
  icache_pkg::csr_data_t hits_model = '0;
  icache_pkg::csr_data_t misses_model = '0;
  logic                  en_model = 1'b1;

  icache_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic end_with_failure();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_word(string name, icache_pkg::word_t got, icache_pkg::word_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_csr(string name, icache_pkg::csr_data_t got,
                           icache_pkg::csr_data_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_addr(string name, icache_pkg::addr_t got, icache_pkg::addr_t exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_len(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  function automatic void add_op(op_kind_t kind, outcome_t outcome,
                                 icache_pkg::addr_t addr, icache_pkg::csr_data_t data);
    ops.push_back('{kind, outcome, addr, data});
  endfunction

  // set 5 holds tags 0x4 and 0x8d, set 0x2a and 0x2b one tag each
  function automatic void load_table();
    add_op(OP_FETCH,  EXP_MISS, 32'h0000_1050, '0);  // cold miss, low half
    add_op(OP_FETCH,  EXP_HIT,  32'h0000_1058, '0);  // other half
    add_op(OP_FETCH,  EXP_MISS, 32'h0002_3458, '0);  // second tag, same set
    add_op(OP_FETCH,  EXP_HIT,  32'h0002_3450, '0);
    add_op(OP_FETCH,  EXP_HIT,  32'h0000_1054, '0);
    add_op(OP_FETCH,  EXP_MISS, 32'h8000_02a8, '0);
    add_op(OP_FETCH,  EXP_HIT,  32'h8000_02a0, '0);
    add_op(OP_CSR_RD, EXP_NONE, 32'd1, '0);
    add_op(OP_CSR_RD, EXP_NONE, 32'd2, '0);
    add_op(OP_CSR_WR, EXP_NONE, 32'd1, '0);          // clear hit count
    add_op(OP_CSR_RD, EXP_NONE, 32'd1, '0);
    add_op(OP_FETCH,  EXP_HIT,  32'h0000_105c, '0);
    add_op(OP_CSR_WR, EXP_NONE, 32'd0, 32'd3);       // flush, stay enabled
    add_op(OP_FETCH,  EXP_MISS, 32'h0000_1050, '0);
    add_op(OP_FETCH,  EXP_MISS, 32'h0002_3450, '0);
    add_op(OP_FETCH,  EXP_HIT,  32'h0002_3458, '0);
    add_op(OP_CSR_WR, EXP_NONE, 32'd0, 32'd0);       // disable
    add_op(OP_CSR_RD, EXP_NONE, 32'd0, '0);
    add_op(OP_FETCH,  EXP_BYP,  32'h0000_4ab8, '0);
    add_op(OP_FETCH,  EXP_BYP,  32'h0000_1058, '0);  // cached line still bypassed
    add_op(OP_CSR_WR, EXP_NONE, 32'd0, 32'd1);
    add_op(OP_FETCH,  EXP_MISS, 32'h0000_4ab0, '0);  // bypass left it unfilled
    add_op(OP_FETCH,  EXP_HIT,  32'h0000_4ab8, '0);
    add_op(OP_FETCH,  EXP_HIT,  32'h0000_1050, '0);
    add_op(OP_CSR_RD, EXP_NONE, 32'd1, '0);
    add_op(OP_CSR_RD, EXP_NONE, 32'd2, '0);
    add_op(OP_CSR_WR, EXP_NONE, 32'd2, '0);
    add_op(OP_CSR_RD, EXP_NONE, 32'd2, '0);
  endfunction

  function automatic icache_pkg::csr_data_t expected_csr(icache_pkg::csr_addr_t sel);
    case (sel)
      icache_pkg::CSR_CTRL:   return {31'd0, en_model};
      icache_pkg::CSR_HITS:   return hits_model;
      icache_pkg::CSR_MISSES: return misses_model;
      default:                return '0;
    endcase
  endfunction

  task automatic run_fetch(icache_pkg::addr_t addr, outcome_t outcome);
    icache_pkg::addr_t word_addr;
    icache_pkg::addr_t ar_exp;
    int                lat;
    word_addr = {addr[31:3], 3'b000};
    ar_exp = (outcome == EXP_MISS) ? {addr[31:4], 4'b0000} : word_addr;
    fetch_valid_i <= 1'b1;
    fetch_addr_i <= addr;
    @(posedge clk);
    while (!fetch_ready_o) @(posedge clk);
    fetch_valid_i <= 1'b0;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!resp_valid_o);
    if (outcome == EXP_HIT && lat != 2) begin
      $display("hit response for %h came %0d cycles after accept instead of 2", addr, lat);
      end_with_failure();
    end
    while (!resp_ready_i) @(posedge clk);
    check_word("resp_data_o", resp_data_o, {word_addr, ~word_addr});
    if (outcome == EXP_HIT) begin
      hits_model = hits_model + 1;
      if (ar_addr_log.size() != 0) begin
        $display("a memory request was issued for the hit at %h", addr);
        end_with_failure();
      end
    end else begin
      misses_model = misses_model + 1;
      if (ar_addr_log.size() != 1) begin
        $display("expected one memory request for %h, saw %0d", addr, ar_addr_log.size());
        end_with_failure();
      end
      check_addr("mem_ar_addr_o", ar_addr_log.pop_front(), ar_exp);
      check_len("mem_ar_len_o", ar_len_log.pop_front(), outcome == EXP_MISS);
    end
  endtask

  task automatic run_op(op_t op);
    icache_pkg::csr_addr_t sel;
    sel = icache_pkg::csr_addr_t'(op.addr[1:0]);
    case (op.kind)
      OP_FETCH: run_fetch(op.addr, op.outcome);
      OP_CSR_WR: begin
        csr_we_i <= 1'b1;
        csr_addr_i <= sel;
        csr_wdata_i <= op.data;
        @(posedge clk);
        csr_we_i <= 1'b0;
        if (sel == icache_pkg::CSR_CTRL) en_model = op.data[0];
        if (sel == icache_pkg::CSR_HITS) hits_model = '0;
        if (sel == icache_pkg::CSR_MISSES) misses_model = '0;
      end
      default: begin
        csr_addr_i <= sel;
        @(posedge clk);
        check_csr("csr_rdata_o", csr_rdata_o, expected_csr(sel));
      end
    endcase
  endtask

  // memory model: random ar stalls, random gaps between beats
  initial begin : mem_responder
    int unsigned       beats_left;
    icache_pkg::addr_t beat_addr;
    mem_ar_ready_i <= 1'b0;
    mem_r_valid_i <= 1'b0;
    mem_r_data_i <= '0;
    beats_left = 0;
    beat_addr = '0;
    forever begin
      @(posedge clk);
      if (rst) begin
        mem_ar_ready_i <= 1'b0;
        mem_r_valid_i <= 1'b0;
        beats_left = 0;
      end else begin
        if (mem_r_valid_i && mem_r_ready_o) begin
          beats_left = beats_left - 1;
          beat_addr = beat_addr + 32'd8;  // next word of the line
        end
        if (mem_ar_valid_o && mem_ar_ready_i) begin
          ar_addr_log.push_back(mem_ar_addr_o);
          ar_len_log.push_back(mem_ar_len_o);
          beat_addr = mem_ar_addr_o;
          beats_left = mem_ar_len_o ? 2 : 1;
        end
        mem_ar_ready_i <= ($urandom % 4) != 0;
        if (mem_r_valid_i && !mem_r_ready_o) begin
          mem_r_valid_i <= 1'b1;  // hold the beat
        end else if (beats_left != 0 && ($urandom % 3) != 0) begin
          mem_r_valid_i <= 1'b1;
          mem_r_data_i <= {beat_addr, ~beat_addr};
        end else begin
          mem_r_valid_i <= 1'b0;
        end
      end
    end
  end

  initial begin : resp_stall
    resp_ready_i <= 1'b0;
    forever begin
      @(posedge clk);
      resp_ready_i <= !rst && (($urandom % 3) != 0);
    end
  end

  initial begin : watchdog
    wait (table_loaded);
    #(ops.size() * 200 * 100);
    $display("timeout, the stimulus table did not complete in time");
    end_with_failure();
  end

  initial begin : main
    void'($urandom(32'hcf28));
    rst <= 1'b1;
    fetch_valid_i <= 1'b0;
    fetch_addr_i <= '0;
    csr_we_i <= 1'b0;
    csr_addr_i <= '0;
    csr_wdata_i <= '0;
    load_table();
    table_loaded = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < ops.size(); i++) begin
      run_op(ops[i]);
    end
    repeat (2) @(posedge clk);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire
